// ==== id_stage.f ====
+incdir+include
hw/id_pkg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_resolve.sv
hw/id_stage.sv
tests/id_stage_props.sv
tests/id_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= id_stage_tb
FILELIST ?= id_stage.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert
LINT_FLAGS ?= --lint-only --timing --assert

SOURCES := $(wildcard include/*.svh hw/*.sv tests/*.sv)

.PHONY: all sim lint clean

all: sim

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/id_stage_tb.sv ====
`default_nettype none
`include "id_consts.svh"

module id_stage_tb;
	import id_pkg::*;

	localparam int NUM_INST = 3000;
	localparam int MAX_CYCLES = NUM_INST + 50;

	logic clk_i = 1'b0;
	logic rst_n_i;
	word_t pc_i;
	inst_t inst_i;
	logic wb_we_i;
	reg_addr_t wb_waddr_i;
	word_t wb_wdata_i;
	logic ex_wreg_i;
	reg_addr_t ex_wd_i;
	word_t ex_wdata_i;
	aluop_t ex_aluop_i;
	logic mem_wreg_i;
	reg_addr_t mem_wd_i;
	word_t mem_wdata_i;
	logic stall_o;
	logic branch_flag_o;
	word_t branch_target_o;
	aluop_t aluop_o;
	alusel_t alusel_o;
	word_t reg1_o;
	word_t reg2_o;
	reg_addr_t wd_o;
	logic wreg_o;
	word_t link_addr_o;

	integer seed = 32'h0a3028a8;
	int cycles = 0;
	word_t shadow [`ID_NREGS]; // model copy of the register file

	// decoded instruction in the model
	aluop_t d_aluop;
	alusel_t d_alusel;
	logic d_wreg;
	logic d_r1en;
	logic d_r2en;
	reg_addr_t d_r1a;
	reg_addr_t d_r2a;
	reg_addr_t d_wd;
	word_t d_imm;
	word_t d_link;
	word_t d_jt;

	// expected response to the inputs now applied
	logic exp_stall;
	logic exp_bflag;
	word_t exp_btarget;
	aluop_t exp_aluop;
	alusel_t exp_alusel;
	word_t exp_reg1;
	word_t exp_reg2;
	reg_addr_t exp_wd;
	logic exp_wreg;
	word_t exp_link;

	id_stage i_id_stage (.*);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			abort_run($sformatf("timeout, the run did not end within %0d cycles", MAX_CYCLES));
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
	endtask

	task automatic check_aluop(input string name, input aluop_t exp, input aluop_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
	endtask

	task automatic check_alusel(input string name, input alusel_t exp, input alusel_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("FAIL %s: expected %h, got %h", name, exp, act));
	endtask

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	// mostly registers 0..3 so that forwarding and hazards collide often
	function automatic reg_addr_t pick_reg(input logic [7:0] b);
		return (b[7:6] != 2'b00) ? {3'b000, b[1:0]} : b[4:0];
	endfunction

	function automatic inst_t make_inst(input word_t r, input word_t f);
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		op = `ID_OP_SPECIAL;
		fn = 6'h0;
		rs = pick_reg(f[7:0]);
		rt = pick_reg(f[15:8]);
		rd = pick_reg(f[23:16]);
		case (r[4:0])
			5'd0: fn = `ID_FN_OR;
			5'd1: fn = `ID_FN_AND;
			5'd2: fn = `ID_FN_XOR;
			5'd3: fn = `ID_FN_NOR;
			5'd4: fn = `ID_FN_ADDU;
			5'd5: fn = `ID_FN_SUBU;
			5'd6: fn = `ID_FN_SLT;
			5'd7: fn = `ID_FN_SLTU;
			5'd8: fn = `ID_FN_JR;
			5'd9: fn = `ID_FN_SLL;
			5'd10: fn = `ID_FN_SRL;
			5'd11: fn = `ID_FN_SRA;
			5'd12: op = `ID_OP_ORI;
			5'd13: op = `ID_OP_ANDI;
			5'd14: op = `ID_OP_XORI;
			5'd15: op = `ID_OP_LUI;
			5'd16: op = `ID_OP_ADDIU;
			5'd17: op = `ID_OP_SLTI;
			5'd18: op = `ID_OP_SLTIU;
			5'd19: op = `ID_OP_LW;
			5'd20: op = `ID_OP_SW;
			5'd21: op = `ID_OP_BEQ;
			5'd22: op = `ID_OP_BNE;
			5'd23: op = `ID_OP_BGTZ;
			5'd24: op = `ID_OP_BLEZ;
			5'd25: op = `ID_OP_J;
			5'd26: op = `ID_OP_JAL;
			default: return f; // raw word, mostly unknown encodings
		endcase
		if (r[4:0] >= 5'd25)
			return {op, f[25:0]};
		if (r[4:0] >= 5'd12)
			return {op, rs, rt, r[31:16]};
		if (r[4:0] >= 5'd9)
			return {op, 5'd0, rt, rd, f[28:24], fn}; // shift by immediate
		return {op, rs, rt, rd, 5'd0, fn};
	endfunction

	task automatic set_ctl(input aluop_t op, input alusel_t sel, input logic wr,
			input logic r1, input logic r2);
		d_aluop = op;
		d_alusel = sel;
		d_wreg = wr;
		d_r1en = r1;
		d_r2en = r2;
	endtask

	task automatic decode_model(input inst_t inst, input word_t pc);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] sa;
		word_t pc4;
		op = inst[31:26];
		fn = inst[5:0];
		sa = inst[10:6];
		pc4 = pc + 32'd4;
		set_ctl(alu_nop, sel_nop, 1'b0, 1'b0, 1'b0);
		d_r1a = inst[25:21];
		d_r2a = inst[20:16];
		d_wd = (op == `ID_OP_SPECIAL) ? inst[15:11] : inst[20:16];
		d_imm = '0;
		d_link = '0;
		d_jt = {pc4[31:28], inst[25:0], 2'b00};
		if (op == `ID_OP_SPECIAL && sa == 5'd0) begin
			case (fn)
				`ID_FN_OR: set_ctl(alu_or, sel_logic, 1'b1, 1'b1, 1'b1);
				`ID_FN_AND: set_ctl(alu_and, sel_logic, 1'b1, 1'b1, 1'b1);
				`ID_FN_XOR: set_ctl(alu_xor, sel_logic, 1'b1, 1'b1, 1'b1);
				`ID_FN_NOR: set_ctl(alu_nor, sel_logic, 1'b1, 1'b1, 1'b1);
				`ID_FN_ADDU: set_ctl(alu_addu, sel_arith, 1'b1, 1'b1, 1'b1);
				`ID_FN_SUBU: set_ctl(alu_subu, sel_arith, 1'b1, 1'b1, 1'b1);
				`ID_FN_SLT: set_ctl(alu_slt, sel_arith, 1'b1, 1'b1, 1'b1);
				`ID_FN_SLTU: set_ctl(alu_sltu, sel_arith, 1'b1, 1'b1, 1'b1);
				`ID_FN_JR: set_ctl(alu_jr, sel_jump_branch, 1'b0, 1'b1, 1'b0);
				default: ;
			endcase
		end
		if (op == `ID_OP_SPECIAL && inst[25:21] == 5'd0) begin
			case (fn)
				`ID_FN_SLL: set_ctl(alu_sll, sel_shift, 1'b1, 1'b0, 1'b1);
				`ID_FN_SRL: set_ctl(alu_srl, sel_shift, 1'b1, 1'b0, 1'b1);
				`ID_FN_SRA: set_ctl(alu_sra, sel_shift, 1'b1, 1'b0, 1'b1);
				default: ;
			endcase
			if (d_alusel == sel_shift)
				d_imm = {27'h0, sa};
		end
		case (op)
			`ID_OP_ORI: set_ctl(alu_or, sel_logic, 1'b1, 1'b1, 1'b0);
			`ID_OP_ANDI: set_ctl(alu_and, sel_logic, 1'b1, 1'b1, 1'b0);
			`ID_OP_XORI: set_ctl(alu_xor, sel_logic, 1'b1, 1'b1, 1'b0);
			`ID_OP_LUI: set_ctl(alu_or, sel_logic, 1'b1, 1'b1, 1'b0);
			`ID_OP_ADDIU: set_ctl(alu_addu, sel_arith, 1'b1, 1'b1, 1'b0);
			`ID_OP_SLTI: set_ctl(alu_slt, sel_arith, 1'b1, 1'b1, 1'b0);
			`ID_OP_SLTIU: set_ctl(alu_sltu, sel_arith, 1'b1, 1'b1, 1'b0);
			`ID_OP_LW: set_ctl(alu_lw, sel_load_store, 1'b1, 1'b1, 1'b0);
			`ID_OP_SW: set_ctl(alu_sw, sel_load_store, 1'b0, 1'b1, 1'b1);
			`ID_OP_J: set_ctl(alu_j, sel_jump_branch, 1'b0, 1'b0, 1'b0);
			`ID_OP_JAL: set_ctl(alu_jal, sel_jump_branch, 1'b1, 1'b0, 1'b0);
			`ID_OP_BEQ: set_ctl(alu_beq, sel_jump_branch, 1'b0, 1'b1, 1'b1);
			`ID_OP_BNE: set_ctl(alu_bne, sel_jump_branch, 1'b0, 1'b1, 1'b1);
			`ID_OP_BGTZ: set_ctl(alu_bgtz, sel_jump_branch, 1'b0, 1'b1, 1'b0);
			`ID_OP_BLEZ: set_ctl(alu_blez, sel_jump_branch, 1'b0, 1'b1, 1'b0);
			default: ;
		endcase
		if (op inside {`ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI})
			d_imm = {16'h0, inst[15:0]};
		else if (op == `ID_OP_LUI)
			d_imm = {inst[15:0], 16'h0};
		else if (d_alusel != sel_nop && !(op inside {`ID_OP_SPECIAL, `ID_OP_J, `ID_OP_JAL}))
			d_imm = {{16{inst[15]}}, inst[15:0]}; // arithmetic, memory and branch offsets
		if (op == `ID_OP_JAL) begin
			d_wd = `ID_LINK_REG;
			d_link = pc + 32'd8;
		end
	endtask

	function automatic word_t operand(input logic en, input reg_addr_t a);
		if (!en)
			return d_imm;
		else if (a == '0)
			return '0;
		else if (ex_wreg_i && ex_wd_i == a)
			return ex_wdata_i;
		else if (mem_wreg_i && mem_wd_i == a)
			return mem_wdata_i;
		else if (wb_we_i && wb_waddr_i == a)
			return wb_wdata_i;
		else
			return shadow[a];
	endfunction

	task automatic resolve_model();
		word_t op1;
		word_t op2;
		logic taken;
		op1 = operand(d_r1en, d_r1a);
		op2 = operand(d_r2en, d_r2a);
		exp_stall = (ex_aluop_i == alu_lw) &&
			((d_r1en && ex_wd_i == d_r1a) || (d_r2en && ex_wd_i == d_r2a));
		case (d_aluop)
			alu_beq: taken = (op1 == op2);
			alu_bne: taken = (op1 != op2);
			alu_bgtz: taken = ($signed(op1) > 0);
			alu_blez: taken = ($signed(op1) <= 0);
			default: taken = 1'b0;
		endcase
		exp_bflag = taken || (d_aluop inside {alu_j, alu_jal, alu_jr});
		if (d_aluop == alu_jr)
			exp_btarget = op1 & ~32'h3;
		else if (d_aluop == alu_j || d_aluop == alu_jal)
			exp_btarget = d_jt;
		else if (taken)
			exp_btarget = pc_i + 32'd4 + (d_imm << 2);
		else
			exp_btarget = '0;
		exp_aluop = exp_stall ? alu_nop : d_aluop; // bubble on stall
		exp_alusel = exp_stall ? sel_nop : d_alusel;
		exp_reg1 = exp_stall ? '0 : op1;
		exp_reg2 = exp_stall ? '0 : op2;
		exp_wd = exp_stall ? '0 : d_wd;
		exp_wreg = exp_stall ? 1'b0 : d_wreg;
		exp_link = exp_stall ? '0 : d_link;
		if (wb_we_i && wb_waddr_i != '0) // takes effect at the coming edge
			shadow[wb_waddr_i] = wb_wdata_i;
	endtask

	task automatic drive_inputs();
		word_t r;
		word_t f;
		r = rand_word();
		f = rand_word();
		inst_i = make_inst(r, f);
		r = rand_word();
		pc_i = {r[31:2], 2'b00};
		r = rand_word();
		wb_we_i = r[0];
		ex_wreg_i = r[1];
		mem_wreg_i = r[2];
		case (r[5:3])
			3'd0, 3'd1: ex_aluop_i = alu_lw;
			3'd2: ex_aluop_i = alu_sw;
			3'd3: ex_aluop_i = alu_or;
			default: ex_aluop_i = alu_addu;
		endcase
		wb_waddr_i = pick_reg(r[15:8]);
		ex_wd_i = pick_reg(r[23:16]);
		mem_wd_i = pick_reg(r[31:24]);
		wb_wdata_i = rand_word();
		ex_wdata_i = rand_word();
		mem_wdata_i = rand_word();
	endtask

	task automatic compare_outputs();
		check_bit("stall_o", exp_stall, stall_o);
		check_bit("branch_flag_o", exp_bflag, branch_flag_o);
		check_word("branch_target_o", exp_btarget, branch_target_o);
		check_aluop("aluop_o", exp_aluop, aluop_o);
		check_alusel("alusel_o", exp_alusel, alusel_o);
		check_word("reg1_o", exp_reg1, reg1_o);
		check_word("reg2_o", exp_reg2, reg2_o);
		check_addr("wd_o", exp_wd, wd_o);
		check_bit("wreg_o", exp_wreg, wreg_o);
		check_word("link_addr_o", exp_link, link_addr_o);
	endtask

	initial begin
		rst_n_i = 1'b0;
		pc_i = '0;
		inst_i = '0;
		wb_we_i = 1'b0;
		wb_waddr_i = '0;
		wb_wdata_i = '0;
		ex_wreg_i = 1'b0;
		ex_wd_i = '0;
		ex_wdata_i = '0;
		ex_aluop_i = alu_nop;
		mem_wreg_i = 1'b0;
		mem_wd_i = '0;
		mem_wdata_i = '0;
		for (int i = 0; i < `ID_NREGS; i++)
			shadow[i] = '0;
		repeat (10) @(negedge clk_i);
		check_aluop("aluop_o", alu_nop, aluop_o);
		check_alusel("alusel_o", sel_nop, alusel_o);
		check_word("reg1_o", '0, reg1_o);
		check_word("reg2_o", '0, reg2_o);
		check_addr("wd_o", '0, wd_o);
		check_bit("wreg_o", 1'b0, wreg_o);
		check_word("link_addr_o", '0, link_addr_o);
		rst_n_i = 1'b1;
		for (int n = 0; n < NUM_INST; n++) begin
			drive_inputs();
			decode_model(inst_i, pc_i);
			resolve_model();
			@(negedge clk_i);
			compare_outputs();
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/id_stage_props.sv ====
`default_nettype none

module id_stage_props (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic stall_i,
	input wire logic wreg_i,
	input wire logic branch_flag_i,
	input wire id_pkg::word_t branch_target_i
);

	// a stalled cycle leaves a bubble in ID/EX
	stall_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		stall_i |=> !wreg_i)
		else $error("stall not followed by a bubble");

	reset_no_write: assert property (@(posedge clk_i)
		!rst_n_i |=> !wreg_i)
		else $error("wreg_o high in the first cycle after reset");

	target_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		branch_flag_i |-> branch_target_i[1:0] == 2'b00) // word aligned
		else $error("branch target not word aligned");

endmodule

bind id_stage id_stage_props i_id_stage_props (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.stall_i(stall_o),
	.wreg_i(wreg_o),
	.branch_flag_i(branch_flag_o),
	.branch_target_i(branch_target_o)
);

`default_nettype wire

// ==== hw/id_stage.sv ====
`default_nettype none

module id_stage (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire id_pkg::word_t pc_i,
	input wire id_pkg::inst_t inst_i,
	input wire logic wb_we_i,
	input wire id_pkg::reg_addr_t wb_waddr_i,
	input wire id_pkg::word_t wb_wdata_i,
	input wire logic ex_wreg_i,
	input wire id_pkg::reg_addr_t ex_wd_i,
	input wire id_pkg::word_t ex_wdata_i,
	input wire id_pkg::aluop_t ex_aluop_i,
	input wire logic mem_wreg_i,
	input wire id_pkg::reg_addr_t mem_wd_i,
	input wire id_pkg::word_t mem_wdata_i,
	output logic stall_o,
	output logic branch_flag_o,
	output id_pkg::word_t branch_target_o,
	output id_pkg::aluop_t aluop_o,
	output id_pkg::alusel_t alusel_o,
	output id_pkg::word_t reg1_o,
	output id_pkg::word_t reg2_o,
	output id_pkg::reg_addr_t wd_o,
	output logic wreg_o,
	output id_pkg::word_t link_addr_o
);
	import id_pkg::*;

	aluop_t dec_aluop;
	alusel_t dec_alusel;
	logic dec_wreg;
	reg_addr_t dec_wd;
	logic reg1_read;
	logic reg2_read;
	reg_addr_t reg1_addr;
	reg_addr_t reg2_addr;
	word_t dec_imm;
	word_t dec_link_addr;
	word_t dec_jump_target;
	word_t rdata1;
	word_t rdata2;

	inst_decoder i_inst_decoder (
		.inst_i(inst_i), .pc_i(pc_i),
		.aluop_o(dec_aluop), .alusel_o(dec_alusel), .wreg_o(dec_wreg), .wd_o(dec_wd),
		.reg1_read_o(reg1_read), .reg2_read_o(reg2_read),
		.reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
		.imm_o(dec_imm), .link_addr_o(dec_link_addr), .jump_target_o(dec_jump_target)
	);

	regfile i_regfile (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.we_i(wb_we_i), .waddr_i(wb_waddr_i), .wdata_i(wb_wdata_i),
		.re1_i(reg1_read), .raddr1_i(reg1_addr), .re2_i(reg2_read), .raddr2_i(reg2_addr),
		.rdata1_o(rdata1), .rdata2_o(rdata2)
	);

	operand_resolve i_operand_resolve (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .pc_i(pc_i),
		.aluop_i(dec_aluop), .alusel_i(dec_alusel), .wreg_i(dec_wreg), .wd_i(dec_wd),
		.reg1_read_i(reg1_read), .reg2_read_i(reg2_read),
		.reg1_addr_i(reg1_addr), .reg2_addr_i(reg2_addr),
		.imm_i(dec_imm), .link_addr_i(dec_link_addr), .jump_target_i(dec_jump_target),
		.rdata1_i(rdata1), .rdata2_i(rdata2),
		.ex_wreg_i(ex_wreg_i), .ex_wd_i(ex_wd_i), .ex_wdata_i(ex_wdata_i),
		.ex_aluop_i(ex_aluop_i),
		.mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
		.stall_o(stall_o), .branch_flag_o(branch_flag_o), .branch_target_o(branch_target_o),
		.aluop_o(aluop_o), .alusel_o(alusel_o), .reg1_o(reg1_o), .reg2_o(reg2_o),
		.wd_o(wd_o), .wreg_o(wreg_o), .link_addr_o(link_addr_o)
	);

endmodule

`default_nettype wire

// ==== hw/operand_resolve.sv ====
`default_nettype none

module operand_resolve (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire id_pkg::word_t pc_i,
	input wire id_pkg::aluop_t aluop_i,
	input wire id_pkg::alusel_t alusel_i,
	input wire logic wreg_i,
	input wire id_pkg::reg_addr_t wd_i,
	input wire logic reg1_read_i,
	input wire logic reg2_read_i,
	input wire id_pkg::reg_addr_t reg1_addr_i,
	input wire id_pkg::reg_addr_t reg2_addr_i,
	input wire id_pkg::word_t imm_i,
	input wire id_pkg::word_t link_addr_i,
	input wire id_pkg::word_t jump_target_i,
	input wire id_pkg::word_t rdata1_i,
	input wire id_pkg::word_t rdata2_i,
	input wire logic ex_wreg_i,
	input wire id_pkg::reg_addr_t ex_wd_i,
	input wire id_pkg::word_t ex_wdata_i,
	input wire id_pkg::aluop_t ex_aluop_i,
	input wire logic mem_wreg_i,
	input wire id_pkg::reg_addr_t mem_wd_i,
	input wire id_pkg::word_t mem_wdata_i,
	output logic stall_o,
	output logic branch_flag_o,
	output id_pkg::word_t branch_target_o,
	output id_pkg::aluop_t aluop_o,
	output id_pkg::alusel_t alusel_o,
	output id_pkg::word_t reg1_o,
	output id_pkg::word_t reg2_o,
	output id_pkg::reg_addr_t wd_o,
	output logic wreg_o,
	output id_pkg::word_t link_addr_o
);
	import id_pkg::*;

	word_t reg1_val;
	word_t reg2_val;
	word_t rel_target;
	logic rel_taken;

	// newest producer first, $0 is never forwarded
	function automatic word_t pick_operand(input logic rd_en, input reg_addr_t addr,
			input word_t rf_data);
		if (!rd_en)
			return imm_i;
		else if (ex_wreg_i && ex_wd_i == addr && addr != '0)
			return ex_wdata_i;
		else if (mem_wreg_i && mem_wd_i == addr && addr != '0)
			return mem_wdata_i;
		else
			return rf_data;
	endfunction

	always_comb begin
		reg1_val = pick_operand(reg1_read_i, reg1_addr_i, rdata1_i);
		reg2_val = pick_operand(reg2_read_i, reg2_addr_i, rdata2_i);
	end

	// loaded word not ready until after mem
	assign stall_o = (ex_aluop_i == alu_lw) &&
		((reg1_read_i && ex_wd_i == reg1_addr_i) || (reg2_read_i && ex_wd_i == reg2_addr_i));

	assign rel_target = pc_i + 32'd4 + {imm_i[29:0], 2'b00};

	always_comb begin
		case (aluop_i)
			alu_beq: rel_taken = (reg1_val == reg2_val);
			alu_bne: rel_taken = (reg1_val != reg2_val);
			alu_bgtz: rel_taken = !reg1_val[31] && reg1_val != '0;
			alu_blez: rel_taken = reg1_val[31] || reg1_val == '0;
			default: rel_taken = 1'b0;
		endcase
	end

	always_comb begin
		branch_flag_o = 1'b1;
		if (aluop_i == alu_j || aluop_i == alu_jal)
			branch_target_o = jump_target_i;
		else if (aluop_i == alu_jr)
			branch_target_o = {reg1_val[31:2], 2'b00}; // word aligned
		else if (rel_taken)
			branch_target_o = rel_target;
		else begin
			branch_flag_o = 1'b0;
			branch_target_o = '0;
		end
	end

	// ID/EX register, a stall loads a bubble
	always_ff @(posedge clk_i) begin
		if (!rst_n_i || stall_o) begin
			aluop_o <= alu_nop;
			alusel_o <= sel_nop;
			reg1_o <= '0;
			reg2_o <= '0;
			wd_o <= '0;
			wreg_o <= 1'b0;
			link_addr_o <= '0;
		end else begin
			aluop_o <= aluop_i;
			alusel_o <= alusel_i;
			reg1_o <= reg1_val;
			reg2_o <= reg2_val;
			wd_o <= wd_i;
			wreg_o <= wreg_i;
			link_addr_o <= link_addr_i;
		end
	end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
`default_nettype none
`include "id_consts.svh"

module regfile (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic we_i,
	input wire id_pkg::reg_addr_t waddr_i,
	input wire id_pkg::word_t wdata_i,
	input wire logic re1_i,
	input wire id_pkg::reg_addr_t raddr1_i,
	input wire logic re2_i,
	input wire id_pkg::reg_addr_t raddr2_i,
	output id_pkg::word_t rdata1_o,
	output id_pkg::word_t rdata2_o
);
	import id_pkg::*;

	word_t regs [`ID_NREGS];

	// same-cycle write-back wins over the stored word
	function automatic word_t read_port(input logic re, input reg_addr_t raddr);
		if (!re || raddr == '0)
			return '0;
		else if (we_i && waddr_i == raddr)
			return wdata_i;
		else
			return regs[raddr];
	endfunction

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `ID_NREGS; i++)
				regs[i] <= '0;
		end else if (we_i && waddr_i != '0) begin // $0 stays zero
			regs[waddr_i] <= wdata_i;
		end
	end

	always_comb begin
		rdata1_o = read_port(re1_i, raddr1_i);
		rdata2_o = read_port(re2_i, raddr2_i);
	end

endmodule

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`default_nettype none
`include "id_consts.svh"

module inst_decoder (
	input wire id_pkg::inst_t inst_i,
	input wire id_pkg::word_t pc_i,
	output id_pkg::aluop_t aluop_o,
	output id_pkg::alusel_t alusel_o,
	output logic wreg_o,
	output id_pkg::reg_addr_t wd_o,
	output logic reg1_read_o,
	output logic reg2_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output id_pkg::word_t imm_o,
	output id_pkg::word_t link_addr_o,
	output id_pkg::word_t jump_target_o
);
	import id_pkg::*;

	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] shamt;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t imm_sext;
	word_t pc_plus_4;

	assign op = inst_i[31:26];
	assign rs = inst_i[25:21];
	assign rt = inst_i[20:16];
	assign rd = inst_i[15:11];
	assign shamt = inst_i[10:6];
	assign funct = inst_i[5:0];
	assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
	assign pc_plus_4 = pc_i + 32'd4;

	always_comb begin
		aluop_o = alu_nop;
		case (op)
			`ID_OP_SPECIAL: begin
				if (rs == '0) begin // shift by immediate
					case (funct)
						`ID_FN_SLL: aluop_o = alu_sll;
						`ID_FN_SRL: aluop_o = alu_srl;
						`ID_FN_SRA: aluop_o = alu_sra;
						default: aluop_o = alu_nop;
					endcase
				end
				if (shamt == '0) begin
					case (funct)
						`ID_FN_OR: aluop_o = alu_or;
						`ID_FN_AND: aluop_o = alu_and;
						`ID_FN_XOR: aluop_o = alu_xor;
						`ID_FN_NOR: aluop_o = alu_nor;
						`ID_FN_ADDU: aluop_o = alu_addu;
						`ID_FN_SUBU: aluop_o = alu_subu;
						`ID_FN_SLT: aluop_o = alu_slt;
						`ID_FN_SLTU: aluop_o = alu_sltu;
						`ID_FN_JR: aluop_o = alu_jr;
						default: ;
					endcase
				end
			end
			`ID_OP_ORI, `ID_OP_LUI: aluop_o = alu_or; // lui ors the upper half into $0
			`ID_OP_ANDI: aluop_o = alu_and;
			`ID_OP_XORI: aluop_o = alu_xor;
			`ID_OP_ADDIU: aluop_o = alu_addu;
			`ID_OP_SLTI: aluop_o = alu_slt;
			`ID_OP_SLTIU: aluop_o = alu_sltu;
			`ID_OP_LW: aluop_o = alu_lw;
			`ID_OP_SW: aluop_o = alu_sw;
			`ID_OP_J: aluop_o = alu_j;
			`ID_OP_JAL: aluop_o = alu_jal;
			`ID_OP_BEQ: aluop_o = alu_beq;
			`ID_OP_BNE: aluop_o = alu_bne;
			`ID_OP_BGTZ: aluop_o = alu_bgtz;
			`ID_OP_BLEZ: aluop_o = alu_blez;
			default: aluop_o = alu_nop;
		endcase
	end

	// class and register use follow from the operation
	always_comb begin
		alusel_o = sel_nop;
		wreg_o = 1'b0;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		case (aluop_o)
			alu_or, alu_and, alu_xor, alu_nor,
			alu_addu, alu_subu, alu_slt, alu_sltu: begin
				alusel_o = (aluop_o inside {alu_or, alu_and, alu_xor, alu_nor}) ?
					sel_logic : sel_arith;
				wreg_o = 1'b1;
				reg1_read_o = 1'b1;
				reg2_read_o = (op == `ID_OP_SPECIAL); // immediate forms take imm instead
			end
			alu_sll, alu_srl, alu_sra: begin
				alusel_o = sel_shift;
				wreg_o = 1'b1;
				reg2_read_o = 1'b1; // reg1 carries shamt
			end
			alu_lw: begin
				alusel_o = sel_load_store;
				wreg_o = 1'b1;
				reg1_read_o = 1'b1;
			end
			alu_sw: begin
				alusel_o = sel_load_store;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
			end
			alu_j, alu_jal: begin
				alusel_o = sel_jump_branch;
				wreg_o = (aluop_o == alu_jal);
			end
			alu_jr, alu_bgtz, alu_blez: begin
				alusel_o = sel_jump_branch;
				reg1_read_o = 1'b1;
			end
			alu_beq, alu_bne: begin
				alusel_o = sel_jump_branch;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (op)
			`ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI: imm_o = {16'h0, inst_i[15:0]};
			`ID_OP_LUI: imm_o = {inst_i[15:0], 16'h0};
			`ID_OP_ADDIU, `ID_OP_SLTI, `ID_OP_SLTIU, `ID_OP_LW, `ID_OP_SW,
			`ID_OP_BEQ, `ID_OP_BNE, `ID_OP_BGTZ, `ID_OP_BLEZ: imm_o = imm_sext;
			default: imm_o = (alusel_o == sel_shift) ? {27'h0, shamt} : '0;
		endcase
	end

	assign reg1_addr_o = rs;
	assign reg2_addr_o = rt;
	assign wd_o = (op == `ID_OP_SPECIAL) ? rd : ((op == `ID_OP_JAL) ? `ID_LINK_REG : rt);
	assign link_addr_o = (aluop_o == alu_jal) ? pc_i + 32'd8 : '0; // past the delay slot
	assign jump_target_o = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

endmodule

`default_nettype wire

// ==== hw/id_pkg.sv ====
`default_nettype none
`include "id_consts.svh"

package id_pkg;

	typedef logic [`ID_WORD_W-1:0] word_t;
	typedef logic [`ID_REG_AW-1:0] reg_addr_t;
	typedef logic [`ID_WORD_W-1:0] inst_t;

	// operation handed to execute, nop must stay 0 for the bubble
	typedef enum logic [4:0] {
		alu_nop = 5'd0,
		alu_or, alu_and, alu_xor, alu_nor,
		alu_addu, alu_subu, alu_slt, alu_sltu,
		alu_sll, alu_srl, alu_sra,
		alu_lw, alu_sw,
		alu_j, alu_jal, alu_jr,
		alu_beq, alu_bne, alu_bgtz, alu_blez
	} aluop_t;

	// result class
	typedef enum logic [2:0] {
		sel_nop = 3'd0,
		sel_logic,
		sel_shift,
		sel_arith,
		sel_jump_branch,
		sel_load_store
	} alusel_t;

endpackage

`default_nettype wire

// ==== include/id_consts.svh ====
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define ID_WORD_W    32
`define ID_REG_AW    5
`define ID_NREGS     32
`define ID_LINK_REG  5'd31
`define ID_RESET_PC  32'h0000_0000

// primary opcodes, inst[31:26]
`define ID_OP_SPECIAL  6'b000000
`define ID_OP_ORI      6'b001101
`define ID_OP_ANDI     6'b001100
`define ID_OP_XORI     6'b001110
`define ID_OP_LUI      6'b001111
`define ID_OP_ADDIU    6'b001001
`define ID_OP_SLTI     6'b001010
`define ID_OP_SLTIU    6'b001011
`define ID_OP_LW       6'b100011
`define ID_OP_SW       6'b101011
`define ID_OP_J        6'b000010
`define ID_OP_JAL      6'b000011
`define ID_OP_BEQ      6'b000100
`define ID_OP_BNE      6'b000101
`define ID_OP_BGTZ     6'b000111
`define ID_OP_BLEZ     6'b000110

// SPECIAL funct, inst[5:0]
`define ID_FN_OR    6'b100101
`define ID_FN_AND   6'b100100
`define ID_FN_XOR   6'b100110
`define ID_FN_NOR   6'b100111
`define ID_FN_ADDU  6'b100001
`define ID_FN_SUBU  6'b100011
`define ID_FN_SLT   6'b101010
`define ID_FN_SLTU  6'b101011
`define ID_FN_SLL   6'b000000
`define ID_FN_SRL   6'b000010
`define ID_FN_SRA   6'b000011
`define ID_FN_JR    6'b001000

`endif
